//--- cen_divider.sv
//////////////////////////////
// nominal cpu clock enable
// one pulse every CEN_DIV clocks while start is high
// first pulse CEN_DIV-1 cycles after start is seen
//////////////////////////////
`include "wait_macros.svh"

module cen_divider (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic cen_nom
);

    // enough bits to hold CEN_DIV-1
    localparam int DIV_W = $clog2(`CEN_DIV);
    localparam logic [DIV_W-1:0] RELOAD = DIV_W'(`CEN_DIV - 1);

    logic [DIV_W-1:0] cnt;
    logic             expired;

    // counter hit zero on the previous edge
    assign expired = (cnt == '0);

    //////////////////////////////
    // down counter
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= RELOAD;
            cen_nom <= 1'b0;
        end else if (!start) begin
            // held reloaded, so a rising start restarts the count
            cnt     <= RELOAD;
            cen_nom <= 1'b0;
        end else begin
            cen_nom <= expired;
            if (expired) begin
                cnt <= RELOAD;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

//--- cen_recover.sv
//////////////////////////////
// swallowed enable recovery
// counts nominal enables blocked by the gate
// pays them back on idle bus cycles between enables
// cen_out is combinational
//////////////////////////////

module cen_recover (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   cen_nom,
    input  logic                   gate,
    input  cpu_bus_pkg::cpu_ctrl_t bus,
    output logic                   cen_out
);

    cpu_bus_pkg::miss_cnt_t miss_cnt;

    logic bus_idle;
    logic owed;
    logic missed;
    logic full;
    logic rec;

    //////////////////////////////
    // recovery condition
    //////////////////////////////

    // no memory, i/o or bus-grant activity
    assign bus_idle = bus.mreq_n & bus.iorq_n & bus.busak_n;

    assign owed = |miss_cnt;
    // stop counting at all ones, further misses are lost
    assign full = &miss_cnt;

    // a nominal enable arrived while the gate was shut
    assign missed = cen_nom & ~gate;

    // extra enable only between nominal ones
    // so the two never land on the same cycle
    assign rec = owed & ~cen_nom & bus_idle;

    // passed nominal enables plus recovery pulses
    assign cen_out = (cen_nom & gate) | rec;

    //////////////////////////////
    // owed enable counter
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_cnt <= '0;
        end else if (!start) begin
            // cpu halted, the debt is forgiven
            miss_cnt <= '0;
        end else if (missed) begin
            if (!full) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end else if (rec) begin
            // rec implies owed, no underflow
            miss_cnt <= miss_cnt - 1'b1;
        end
    end

endmodule

//--- cpu_bus_pkg.sv
//////////////////////////////
// cpu side types
// bus activity, owed-enable count, device busy flags
// referenced as cpu_bus_pkg::name
//////////////////////////////
`include "wait_macros.svh"

package cpu_bus_pkg;

    //////////////////////////////
    // counters and flags
    //////////////////////////////

    // number of enables still owed to the cpu
    typedef logic [`MISS_CNT_W-1:0] miss_cnt_t;

    // one bit per shared-memory device, high = busy
    typedef logic [`DEV_CNT-1:0] dev_busy_t;

    //////////////////////////////
    // bus activity
    //////////////////////////////

    // all active low, all high means the bus is idle
    // and a recovery enable cannot corrupt a transfer
    typedef struct packed {
        // memory request
        logic mreq_n;
        // i/o request
        logic iorq_n;
        // bus acknowledge, bus lent to another master
        logic busak_n;
    } cpu_ctrl_t;

endpackage

//--- cpu_wait_top.sv
//////////////////////////////
// cpu clock enable gating, top level
// divider makes the nominal enable, the rom gate closes it
// and the recovery block pays missed enables back
// cen_out drives the cpu clock enable
//////////////////////////////

module cpu_wait_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    // cpu bus activity, gates recovery
    input  cpu_bus_pkg::cpu_ctrl_t bus,
    // shared memory devices
    input  cpu_bus_pkg::dev_busy_t dev_busy,
    // rom select and sdram data valid
    input  rom_bus_pkg::rom_req_t  rom,
    output logic                   cen_out,
    output logic                   gate
);

    // nominal enable, before gating
    logic cen_nom;

    //////////////////////////////
    // enable generation
    //////////////////////////////
    cen_divider i_cen_divider (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .start   ( start   ),
        .cen_nom ( cen_nom )
    );

    //////////////////////////////
    // rom and device wait
    //////////////////////////////
    rom_gate i_rom_gate (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .start    ( start    ),
        .rom      ( rom      ),
        .dev_busy ( dev_busy ),
        .gate     ( gate     )
    );

    //////////////////////////////
    // missed enable recovery
    //////////////////////////////
    cen_recover i_cen_recover (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .start   ( start   ),
        .cen_nom ( cen_nom ),
        .gate    ( gate    ),
        .bus     ( bus     ),
        .cen_out ( cen_out )
    );

endmodule

//--- rom_bus_pkg.sv
//////////////////////////////
// memory side types
// rom request from the cpu and the gate FSM states
// referenced as rom_bus_pkg::name
//////////////////////////////

package rom_bus_pkg;

    // rom access as seen from the sdram side
    typedef struct packed {
        // cpu is selecting rom, level
        logic cs;
        // sdram data valid for the current address, level
        logic ok;
    } rom_req_t;

    // why the gate is closed
    // the three wait states hold the lock for one cycle
    typedef enum logic [2:0] {
        // nothing pending
        gs_open      = 3'd0,
        // new rom select seen, data not trusted yet
        gs_edge_wait = 3'd1,
        // select held but sdram not ready
        gs_data_wait = 3'd2,
        // a shared device was busy
        gs_busy_wait = 3'd3,
        // lock just dropped, gate open again
        gs_release   = 3'd4
    } gate_state_t;

endpackage

//--- rom_gate.sv
//////////////////////////////
// rom wait gate
// closes the cpu enable while rom data is not valid
// or a shared device is busy, zero latency on gate
// one cycle of lock after the last blocking cycle
//////////////////////////////

module rom_gate (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  rom_bus_pkg::rom_req_t  rom,
    input  cpu_bus_pkg::dev_busy_t dev_busy,
    output logic                   gate
);

    rom_bus_pkg::gate_state_t state;
    rom_bus_pkg::gate_state_t state_nxt;

    logic last_cs;
    logic cs_rise;
    logic data_bad;
    logic any_busy;
    logic blocked;
    logic locked;

    //////////////////////////////
    // blocking terms
    //////////////////////////////

    // first cycle of a new address, ok may belong to the old one
    assign cs_rise  = rom.cs & ~last_cs;
    // select held but sdram still fetching
    assign data_bad = rom.cs & ~rom.ok;
    assign any_busy = |dev_busy;
    assign blocked  = cs_rise | data_bad | any_busy;

    // lock is held by the three wait states
    assign locked = (state == rom_bus_pkg::gs_edge_wait) ||
                    (state == rom_bus_pkg::gs_data_wait) ||
                    (state == rom_bus_pkg::gs_busy_wait);

    // combinational, no register between inputs and gate
    assign gate = start & ~blocked & ~locked;

    //////////////////////////////
    // lock FSM
    //////////////////////////////
    always_comb begin
        // edge has priority, then data, then busy devices
        if (cs_rise) begin
            state_nxt = rom_bus_pkg::gs_edge_wait;
        end else if (data_bad) begin
            state_nxt = rom_bus_pkg::gs_data_wait;
        end else if (any_busy) begin
            state_nxt = rom_bus_pkg::gs_busy_wait;
        end else if (locked) begin
            // lock drops now, gate reopens this cycle
            state_nxt = rom_bus_pkg::gs_release;
        end else begin
            state_nxt = rom_bus_pkg::gs_open;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // cs already high at reset is not an edge
            last_cs <= 1'b1;
            state   <= rom_bus_pkg::gs_open;
        end else begin
            last_cs <= rom.cs;
            state   <= state_nxt;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the cpu wait testbench with verilator and run it
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_cpu_wait \
    -f sources.f

# the run may stop on $fatal, the search below decides the result
sim_out=$(./obj_dir/Vtb_cpu_wait 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "^sim passed$"; then
    exit 0
fi

echo "simulation did not report a pass" >&2
exit 1

//--- sources.f
+incdir+.
cpu_bus_pkg.sv
rom_bus_pkg.sv
cen_divider.sv
rom_gate.sv
cen_recover.sv
cpu_wait_top.sv
tb_cpu_wait.sv

//--- tb_cpu_wait.sv
//////////////////////////////
// testbench for the cpu clock enable gating
// applies a table of rom stalls, busy devices, bus activity
// and start drops, one window per row
// a cycle model built from the timing rules predicts gate and
// cen_out every cycle and table rows carry the window totals
//////////////////////////////
`include "wait_macros.svh"

module tb_cpu_wait;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int MARGIN_CYCLES = 64;
    localparam int NUM_ROWS      = 8;
    localparam logic [31:0] SEED = 32'h7713ac86;

    // one window of stimulus, offsets are cycles inside the window
    // exp_* of -1 means the model alone gives the expected value
    typedef struct packed {
        int                     win_len;
        int                     cs_off;
        int                     cs_len;
        // cycles of ok low after the select rises
        int                     stall_len;
        // stall length from the lfsr instead
        logic                   rand_stall;
        cpu_bus_pkg::dev_busy_t busy_pat;
        int                     busy_off;
        int                     busy_len;
        // mreq_n active 3 of every 4 cycles for this many cycles
        int                     mreq_len;
        // start low window
        int                     stop_off;
        int                     stop_len;
        int                     exp_pulses;
        int                     exp_gate_low;
    } row_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    cpu_bus_pkg::cpu_ctrl_t bus;
    cpu_bus_pkg::dev_busy_t dev_busy;
    rom_bus_pkg::rom_req_t  rom;
    logic                   cen_out;
    logic                   gate;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr;

    // model state
    int                     m_run;
    logic                   m_nom;
    logic                   m_last_cs;
    logic                   m_lock;
    cpu_bus_pkg::miss_cnt_t m_cnt;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_wait_top i_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .start    ( start    ),
        .bus      ( bus      ),
        .dev_busy ( dev_busy ),
        .rom      ( rom      ),
        .cen_out  ( cen_out  ),
        .gate     ( gate     )
    );

    //////////////////////////////
    // random source
    //////////////////////////////

    // galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_count(input string name, input int exp, input int act);
        if (exp !== act) begin
            $display("error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            $display("sim failed");
            $fatal(1, "first count mismatch, run stopped");
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            $display("sim failed");
            $fatal(1, "first level mismatch, run stopped");
        end
    endtask

    //////////////////////////////
    // cycle model
    //////////////////////////////

    // outputs from the current inputs, then the state for the next edge
    task automatic model_cycle(output logic g, output logic cen);
        logic blocked;
        logic rec;
        // new select, data not valid, or a busy device
        blocked = (rom.cs & ~m_last_cs) | (rom.cs & ~rom.ok) | (|dev_busy);
        g       = start & ~blocked & ~m_lock;
        // payback only between nominal enables on an idle bus
        rec     = (m_cnt != '0) & ~m_nom & bus.mreq_n & bus.iorq_n & bus.busak_n;
        cen     = (m_nom & g) | rec;

        if (!start) begin
            m_cnt = '0;
        end else if (m_nom && !g) begin
            if (m_cnt != '1) begin
                m_cnt = m_cnt + cpu_bus_pkg::miss_cnt_t'(1);
            end
        end else if (rec) begin
            m_cnt = m_cnt - cpu_bus_pkg::miss_cnt_t'(1);
        end
        m_lock    = blocked;
        m_last_cs = rom.cs;
        // cycles since start was sampled, enable on every CEN_DIV-th
        if (!start) begin
            m_run = 0;
            m_nom = 1'b0;
        end else begin
            m_run = m_run + 1;
            m_nom = (m_run % `CEN_DIV == 0);
        end
    endtask

    //////////////////////////////
    // one table row
    //////////////////////////////
    task automatic run_row(input int idx);
        row_t r;
        int   c;
        int   stall;
        logic in_cs;
        logic m_g;
        logic m_cen;
        int   n_out;
        int   n_low;
        r     = rows[idx];
        stall = r.stall_len;
        if (r.rand_stall) begin
            // sdram latency between 4 and 19 cycles
            take_bits(4, stall);
            stall = stall + 4;
            $display("row %0d: ok latency %0d cycles", idx, stall);
        end
        n_out = 0;
        n_low = 0;
        for (c = 0; c < r.win_len; c++) begin
            @(posedge clk);
            #2;
            in_cs    = (c >= r.cs_off) && (c < r.cs_off + r.cs_len);
            rom.cs   = in_cs;
            rom.ok   = !(in_cs && (c < r.cs_off + stall));
            dev_busy = ((c >= r.busy_off) && (c < r.busy_off + r.busy_len)) ? r.busy_pat : '0;
            // the idle slot lands on the nominal enable, leaving no room to pay back
            bus.mreq_n = (c < r.mreq_len) ? (c % `CEN_DIV == 0) : 1'b1;
            start      = !((c >= r.stop_off) && (c < r.stop_off + r.stop_len));
            // sample at the falling edge, inputs settled
            #8;
            model_cycle(m_g, m_cen);
            check_level("gate", m_g, gate);
            check_level("cen_out", m_cen, cen_out);
            if (cen_out) n_out++;
            if (!gate) n_low++;
        end
        if (r.exp_pulses >= 0) begin
            check_count("cen_out pulses vs table", r.exp_pulses, n_out);
        end
        if (r.exp_gate_low >= 0) begin
            check_count("gate low cycles vs table", r.exp_gate_low, n_low);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin : main_seq
        logic m_g;
        logic m_cen;
        int   i;
        lfsr     = SEED;
        rst_n    = 1'b0;
        start    = 1'b0;
        bus      = '{mreq_n: 1'b1, iorq_n: 1'b1, busak_n: 1'b1};
        dev_busy = '0;
        rom      = '{cs: 1'b0, ok: 1'b0};

        // win cs_off cs_len stall rand busy boff blen mreq soff slen pulses gate_low
        // plain nominal rate, first pulse lost to start-up
        rows[0] = '{40, 0, 0, 0, 1'b0, 2'b00, 0, 0, 0, 0, 0, 9, 0};
        // short stall, paid back in full
        rows[1] = '{80, 4, 20, 16, 1'b0, 2'b00, 0, 0, 0, 0, 0, 20, 17};
        // select edge with ok high, then one busy cycle
        rows[2] = '{40, 8, 8, 0, 1'b0, 2'b10, 24, 1, 0, 0, 0, 10, 4};
        // long stall under mreq, 21 misses and 6 of them lost
        rows[3] = '{120, 4, 84, 80, 1'b0, 2'b00, 0, 0, 88, 0, 0, 24, 81};
        // payback held off until mreq goes idle
        rows[4] = '{80, 4, 12, 10, 1'b0, 2'b00, 0, 0, 40, 0, 0, 20, 11};
        // random ok latency
        rows[5] = '{80, 4, 24, 0, 1'b1, 2'b00, 0, 0, 32, 0, 0, -1, -1};
        // debt built up, then start drops and clears it
        rows[6] = '{80, 4, 20, 16, 1'b0, 2'b00, 0, 0, 28, 24, 8, 12, 25};
        // nominal rate again, no leftover debt
        rows[7] = '{40, 0, 0, 0, 1'b0, 2'b00, 0, 0, 0, 0, 0, 10, 0};

        m_run     = 0;
        m_nom     = 1'b0;
        m_last_cs = 1'b1;
        m_lock    = 1'b0;
        m_cnt     = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // first cycle out of reset, start still low
        #8;
        model_cycle(m_g, m_cen);
        check_level("gate", 1'b0, gate);
        check_level("cen_out", 1'b0, cen_out);

        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("sim passed");
        $finish;
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial begin : watchdog
        int total;
        int i;
        // rows are loaded at time zero
        #1;
        total = RESET_CYCLES + MARGIN_CYCLES;
        for (i = 0; i < NUM_ROWS; i++) begin
            total += rows[i].win_len;
        end
        #(total * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", total);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- wait_macros.svh
//////////////////////////////
// build-time sizes for the cpu clock enable gating
// include where a width or ratio is needed
// the packages build their types on these
//////////////////////////////
`ifndef WAIT_MACROS_SVH
`define WAIT_MACROS_SVH

// width of the swallowed-enable counter
// saturates at all ones, 4 bits -> up to 15 owed enables
`define MISS_CNT_W 4

// shared-memory devices that can hold the cpu
`define DEV_CNT 2

// system clocks per nominal cpu enable
// must be 2 or more
`define CEN_DIV 4

`endif
